// ==== src/vp_settings.svh ====
`ifndef VP_SETTINGS_SVH
`define VP_SETTINGS_SVH

// crop window inside the incoming frame, in input pixels and lines
`define VP_CUT_X0 8
`define VP_CUT_Y0 4
`define VP_CUT_W  40
`define VP_CUT_H  24

// scaled picture size, never larger than the window
`define VP_OUT_W 20
`define VP_OUT_H 12

// display line width, scaled lines are padded with black up to this
`define VP_DISP_W 32

// cdc fifo depth is 2**VP_FIFO_AW words
`define VP_FIFO_AW 6

// scale factors are Q4.14
`define VP_SCALE_FRAC 14

// step = window / output, fixed point
`define VP_X_STEP ((`VP_CUT_W << `VP_SCALE_FRAC) / `VP_OUT_W)
`define VP_Y_STEP ((`VP_CUT_H << `VP_SCALE_FRAC) / `VP_OUT_H)

`endif

// ==== src/vp_pkg.sv ====
`include "vp_settings.svh"

package vp_pkg;

    typedef logic [15:0] pix565_t;  // r5 g6 b5, video in and out
    typedef logic [23:0] pix888_t;  // r8 g8 b8 inside the path

    // pixel or line index
    typedef logic [10:0] coord_t;

    // 4 integer bits on top of the fraction
    typedef logic [`VP_SCALE_FRAC+3:0] scale_t;

    // fifo address plus wrap bit
    typedef logic [`VP_FIFO_AW:0] fifo_ptr_t;

    // crop fsm
    typedef enum logic {
        CUT_WAIT,   // idle until vs rises
        CUT_FRAME   // counting lines of the current frame
    } cut_state_e;

    // line padding fsm
    typedef enum logic {
        FILL_PASS,  // forward scaled pixels
        FILL_PAD    // append black pixels
    } fill_state_e;

endpackage

// ==== src/image_cut.sv ====
`include "vp_settings.svh"

module image_cut (
    input  logic            clk_vi_i,
    input  logic            arst_n_i,
    input  logic            vs_i,
    input  logic            de_i,
    input  vp_pkg::pix565_t pix_i,
    output logic            de_o,
    output vp_pkg::pix888_t pix_o
);

    // window bounds, upper ones exclusive
    localparam vp_pkg::coord_t X_LO = vp_pkg::coord_t'(`VP_CUT_X0);
    localparam vp_pkg::coord_t X_HI = vp_pkg::coord_t'(`VP_CUT_X0 + `VP_CUT_W);
    localparam vp_pkg::coord_t Y_LO = vp_pkg::coord_t'(`VP_CUT_Y0);
    localparam vp_pkg::coord_t Y_HI = vp_pkg::coord_t'(`VP_CUT_Y0 + `VP_CUT_H);

    vp_pkg::cut_state_e state;
    vp_pkg::coord_t     x_cnt;   // pixel within the line
    vp_pkg::coord_t     y_cnt;   // line within the frame
    logic               vs_d;
    logic               de_d;
    logic               vs_rise;
    logic               in_win;

    assign vs_rise = vs_i && !vs_d;

    // current pixel lies inside the crop rectangle
    assign in_win = (state == vp_pkg::CUT_FRAME) && de_i &&
                    (x_cnt >= X_LO) && (x_cnt < X_HI) &&
                    (y_cnt >= Y_LO) && (y_cnt < Y_HI);

    always_ff @(posedge clk_vi_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= vp_pkg::CUT_WAIT;
            x_cnt <= '0;
            y_cnt <= '0;
            vs_d  <= 1'b0;
            de_d  <= 1'b0;
            de_o  <= 1'b0;
        end else begin
            vs_d <= vs_i;
            de_d <= de_i;
            de_o <= in_win;  // one cycle behind de_i
            case (state)
                vp_pkg::CUT_WAIT: begin
                    if (vs_rise) begin  // new frame, restart coordinates
                        state <= vp_pkg::CUT_FRAME;
                        x_cnt <= '0;
                        y_cnt <= '0;
                    end
                end
                vp_pkg::CUT_FRAME: begin
                    if (!vs_i) begin
                        state <= vp_pkg::CUT_WAIT;  // frame over
                    end else if (de_i) begin
                        x_cnt <= x_cnt + 1'b1;
                    end else if (de_d) begin
                        // falling de closes a line
                        x_cnt <= '0;
                        y_cnt <= y_cnt + 1'b1;
                    end
                end
                default: state <= vp_pkg::CUT_WAIT;
            endcase
        end
    end

    // 565 to 888, low bits of each channel zero
    always_ff @(posedge clk_vi_i) begin
        pix_o <= {pix_i[15:11], 3'b000, pix_i[10:5], 2'b00, pix_i[4:0], 3'b000};
    end

endmodule

// ==== src/async_fifo.sv ====
`include "vp_settings.svh"

module async_fifo (
    input  logic            wr_clk_i,
    input  logic            rd_clk_i,
    input  logic            arst_n_i,
    input  logic            wr_en_i,
    input  vp_pkg::pix888_t wr_data_i,
    input  logic            rd_en_i,
    output vp_pkg::pix888_t rd_data_o,
    output logic            empty_o,
    output logic            full_o
);

    localparam int AW    = `VP_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    vp_pkg::pix888_t   mem [DEPTH];

    // write domain
    vp_pkg::fifo_ptr_t wr_bin;
    vp_pkg::fifo_ptr_t wr_gray;
    vp_pkg::fifo_ptr_t wr_bin_nxt;
    vp_pkg::fifo_ptr_t wr_gray_nxt;
    vp_pkg::fifo_ptr_t rq1_gray;   // read pointer, first sync stage
    vp_pkg::fifo_ptr_t rq2_gray;   // read pointer, usable in write domain
    logic              wr_ok;

    // read domain
    vp_pkg::fifo_ptr_t rd_bin;
    vp_pkg::fifo_ptr_t rd_gray;
    vp_pkg::fifo_ptr_t rd_bin_nxt;
    vp_pkg::fifo_ptr_t rd_gray_nxt;
    vp_pkg::fifo_ptr_t wq1_gray;
    vp_pkg::fifo_ptr_t wq2_gray;
    logic              rd_ok;

    function automatic vp_pkg::fifo_ptr_t bin2gray(input vp_pkg::fifo_ptr_t b);
        return b ^ (b >> 1);
    endfunction

    assign wr_ok       = wr_en_i && !full_o;  // writes into a full fifo are lost
    assign wr_bin_nxt  = wr_bin + vp_pkg::fifo_ptr_t'(wr_ok);
    assign wr_gray_nxt = bin2gray(wr_bin_nxt);

    assign rd_ok       = rd_en_i && !empty_o;
    assign rd_bin_nxt  = rd_bin + vp_pkg::fifo_ptr_t'(rd_ok);
    assign rd_gray_nxt = bin2gray(rd_bin_nxt);

    always_ff @(posedge wr_clk_i) begin
        if (wr_ok) mem[wr_bin[AW-1:0]] <= wr_data_i;
    end

    always_ff @(posedge wr_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_bin   <= '0;
            wr_gray  <= '0;
            rq1_gray <= '0;
            rq2_gray <= '0;
            full_o   <= 1'b0;
        end else begin
            wr_bin   <= wr_bin_nxt;
            wr_gray  <= wr_gray_nxt;
            rq1_gray <= rd_gray;
            rq2_gray <= rq1_gray;
            // full when writer is one lap ahead, top two gray bits inverted
            full_o   <= (wr_gray_nxt == {~rq2_gray[AW:AW-1], rq2_gray[AW-2:0]});
        end
    end

    always_ff @(posedge rd_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_bin   <= '0;
            rd_gray  <= '0;
            wq1_gray <= '0;
            wq2_gray <= '0;
            empty_o  <= 1'b1;
        end else begin
            rd_bin   <= rd_bin_nxt;
            rd_gray  <= rd_gray_nxt;
            wq1_gray <= wr_gray;
            wq2_gray <= wq1_gray;
            empty_o  <= (rd_gray_nxt == wq2_gray);  // third rd edge after a write
        end
    end

    // data is valid the cycle after rd_en_i
    always_ff @(posedge rd_clk_i) begin
        if (rd_ok) rd_data_o <= mem[rd_bin[AW-1:0]];
    end

endmodule

// ==== src/stream_scaler.sv ====
`include "vp_settings.svh"

module stream_scaler (
    input  logic            clk_vpm,
    input  logic            arst_n_i,
    input  logic            frame_start_i,
    input  logic            fifo_empty_i,
    input  vp_pkg::pix888_t fifo_data_i,
    input  logic            pad_busy_i,
    output logic            fifo_rd_o,
    output logic            valid_o,
    output vp_pkg::pix888_t pix_o
);

    localparam int FRAC = `VP_SCALE_FRAC;
    localparam int SW   = $bits(vp_pkg::scale_t);

    localparam vp_pkg::coord_t X_LAST = vp_pkg::coord_t'(`VP_CUT_W - 1);
    localparam vp_pkg::coord_t Y_END  = vp_pkg::coord_t'(`VP_CUT_H);
    localparam vp_pkg::coord_t OUT_W  = vp_pkg::coord_t'(`VP_OUT_W);
    localparam vp_pkg::coord_t OUT_H  = vp_pkg::coord_t'(`VP_OUT_H);

    localparam vp_pkg::scale_t ONE    = vp_pkg::scale_t'(1 << FRAC);  // 1.0 in Q4.14
    localparam vp_pkg::scale_t X_STEP = vp_pkg::scale_t'(`VP_X_STEP);
    localparam vp_pkg::scale_t Y_STEP = vp_pkg::scale_t'(`VP_Y_STEP);

    logic           rd_vld;   // fifo_data_i holds a fresh pixel
    vp_pkg::coord_t src_x;    // source position of that pixel
    vp_pkg::coord_t src_y;
    vp_pkg::coord_t out_x;    // pixels emitted in this line
    vp_pkg::coord_t out_y;    // lines emitted in this frame

    // distance from the current source pixel to the next sample point
    // kept relative so the integer part stays inside Q4.14
    vp_pkg::scale_t next_x;
    vp_pkg::scale_t next_y;

    logic           x_hit;
    logic           y_hit;

    // stall while the padder is busy
    assign fifo_rd_o = !fifo_empty_i && !pad_busy_i;

    // sample when the integer part of the distance is zero,
    // i.e. x equals floor(k * step)
    assign x_hit = (next_x[SW-1:FRAC] == '0) && (out_x < OUT_W);
    assign y_hit = (next_y[SW-1:FRAC] == '0) && (out_y < OUT_H) && (src_y < Y_END);

    always_ff @(posedge clk_vpm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_vld  <= 1'b0;
            valid_o <= 1'b0;
            src_x   <= '0;
            src_y   <= '0;
            out_x   <= '0;
            out_y   <= '0;
            next_x  <= '0;
            next_y  <= '0;
        end else begin
            rd_vld  <= fifo_rd_o;
            valid_o <= rd_vld && x_hit && y_hit;  // 2 cycles after fifo_rd_o
            if (frame_start_i) begin
                src_x  <= '0;
                src_y  <= '0;
                out_x  <= '0;
                out_y  <= '0;
                next_x <= '0;
                next_y <= '0;
            end else if (rd_vld) begin
                if (src_x == X_LAST) begin
                    // end of source line
                    src_x  <= '0;
                    out_x  <= '0;
                    next_x <= '0;
                    src_y  <= src_y + 1'b1;
                    if (y_hit) begin
                        next_y <= next_y + Y_STEP - ONE;
                        out_y  <= out_y + 1'b1;
                    end else begin
                        next_y <= next_y - ONE;
                    end
                end else begin
                    src_x <= src_x + 1'b1;
                    if (x_hit) begin
                        next_x <= next_x + X_STEP - ONE;  // jump to next sample
                        out_x  <= out_x + 1'b1;
                    end else begin
                        next_x <= next_x - ONE;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_vpm) begin
        if (rd_vld) pix_o <= fifo_data_i;  // qualified by valid_o
    end

endmodule

// ==== src/fill_blank.sv ====
`include "vp_settings.svh"

module fill_blank (
    input  logic            clk_vpm,
    input  logic            arst_n_i,
    input  logic            frame_start_i,
    input  logic            valid_i,
    input  vp_pkg::pix888_t pix_i,
    output logic            valid_o,
    output vp_pkg::pix888_t pix_o,
    output logic            pad_busy_o
);

    localparam vp_pkg::coord_t LAST_PIX = vp_pkg::coord_t'(`VP_OUT_W - 1);
    localparam vp_pkg::coord_t LAST_PAD = vp_pkg::coord_t'(`VP_DISP_W - `VP_OUT_W - 1);

    vp_pkg::fill_state_e state;
    vp_pkg::coord_t      cnt;       // pixels passed, then black pixels sent
    logic                hold_vld;  // pixel caught during padding
    vp_pkg::pix888_t     hold_pix;
    logic                in_vld;
    vp_pkg::pix888_t     in_pix;

    // held pixel goes first once padding ends
    assign in_vld = valid_i || hold_vld;
    assign in_pix = hold_vld ? hold_pix : pix_i;

    // raised already with the last pixel of a line, so only one read is left in flight
    assign pad_busy_o = (state == vp_pkg::FILL_PAD) || (in_vld && (cnt == LAST_PIX));

    always_ff @(posedge clk_vpm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= vp_pkg::FILL_PASS;
            cnt      <= '0;
            hold_vld <= 1'b0;
            valid_o  <= 1'b0;
        end else if (frame_start_i) begin
            state    <= vp_pkg::FILL_PASS;
            cnt      <= '0;
            hold_vld <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state)
                vp_pkg::FILL_PASS: begin
                    if (in_vld) begin
                        valid_o  <= 1'b1;
                        hold_vld <= 1'b0;
                        if (cnt == LAST_PIX) begin  // line complete, start padding
                            cnt   <= '0;
                            state <= vp_pkg::FILL_PAD;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                vp_pkg::FILL_PAD: begin
                    valid_o <= 1'b1;  // one black pixel per cycle
                    if (valid_i) hold_vld <= 1'b1;
                    if (cnt == LAST_PAD) begin
                        cnt   <= '0;
                        state <= vp_pkg::FILL_PASS;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= vp_pkg::FILL_PASS;
            endcase
        end
    end

    always_ff @(posedge clk_vpm) begin
        if (state == vp_pkg::FILL_PAD) begin
            pix_o <= '0;  // black
        end else if (in_vld) begin
            pix_o <= in_pix;
        end
        if ((state == vp_pkg::FILL_PAD) && valid_i) hold_pix <= pix_i;
    end

endmodule

// ==== src/ahb_vp.sv ====
`include "vp_settings.svh"

module ahb_vp (
    input  logic            clk_vpm,
    input  logic            arst_n_i,

    // video in, vi_clk_i domain
    input  logic            vi_clk_i,
    input  logic            vi_vs_i,
    input  logic            vi_de_i,
    input  vp_pkg::pix565_t vi_data_i,

    // video out, clk_vpm domain except vs
    output logic            vp_vs_o,
    output logic            vp_de_o,
    output vp_pkg::pix565_t vp_data_o
);

    logic            cut_de;
    vp_pkg::pix888_t cut_pix;
    logic            fifo_rd;
    logic            fifo_empty;
    vp_pkg::pix888_t fifo_data;
    logic            sc_valid;
    vp_pkg::pix888_t sc_pix;
    logic            pad_busy;
    logic            fill_valid;
    vp_pkg::pix888_t fill_pix;

    logic            vs_meta;   // first sync flop
    logic            vs_sync;
    logic            vs_prev;   // edge detect
    logic            frame_start;

    // bring vs into clk_vpm and take its rising edge
    always_ff @(posedge clk_vpm or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vs_meta <= 1'b0;
            vs_sync <= 1'b0;
            vs_prev <= 1'b0;
        end else begin
            vs_meta <= vi_vs_i;
            vs_sync <= vs_meta;
            vs_prev <= vs_sync;
        end
    end

    assign frame_start = vs_sync && !vs_prev;

    image_cut u_image_cut (
        .clk_vi_i (vi_clk_i),
        .arst_n_i (arst_n_i),
        .vs_i     (vi_vs_i),
        .de_i     (vi_de_i),
        .pix_i    (vi_data_i),
        .de_o     (cut_de),
        .pix_o    (cut_pix)
    );

    async_fifo u_async_fifo (
        .wr_clk_i  (vi_clk_i),
        .rd_clk_i  (clk_vpm),
        .arst_n_i  (arst_n_i),
        .wr_en_i   (cut_de),
        .wr_data_i (cut_pix),
        .rd_en_i   (fifo_rd),
        .rd_data_o (fifo_data),
        .empty_o   (fifo_empty),
        .full_o    ()           // never reached at nominal clock ratio
    );

    stream_scaler u_stream_scaler (
        .clk_vpm       (clk_vpm),
        .arst_n_i      (arst_n_i),
        .frame_start_i (frame_start),
        .fifo_empty_i  (fifo_empty),
        .fifo_data_i   (fifo_data),
        .pad_busy_i    (pad_busy),
        .fifo_rd_o     (fifo_rd),
        .valid_o       (sc_valid),
        .pix_o         (sc_pix)
    );

    fill_blank u_fill_blank (
        .clk_vpm       (clk_vpm),
        .arst_n_i      (arst_n_i),
        .frame_start_i (frame_start),
        .valid_i       (sc_valid),
        .pix_i         (sc_pix),
        .valid_o       (fill_valid),
        .pix_o         (fill_pix),
        .pad_busy_o    (pad_busy)
    );

    assign vp_vs_o   = vi_vs_i;  // passed straight through
    assign vp_de_o   = fill_valid;
    // keep the top bits of each channel
    assign vp_data_o = {fill_pix[23:19], fill_pix[15:10], fill_pix[7:3]};

endmodule

// ==== verif/tb_ahb_vp.sv ====
`include "vp_settings.svh"

module tb_ahb_vp;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_W   = 64;    // pixels per input line
    localparam int FRAME_H   = 32;    // lines per frame
    localparam int PAD_W     = `VP_DISP_W - `VP_OUT_W;
    localparam int FRAME_PIX = `VP_OUT_H * `VP_DISP_W;
    localparam int WAIT_MAX  = 20000; // clk_vpm cycles allowed per frame
    localparam int BLANK     = 120;   // vi_clk cycles of vertical blanking

    logic            clk_vpm;
    logic            arst_n_i;
    logic            vi_clk_i;
    logic            vi_vs_i;
    logic            vi_de_i;
    vp_pkg::pix565_t vi_data_i;
    logic            vp_vs_o;
    logic            vp_de_o;
    vp_pkg::pix565_t vp_data_o;

    vp_pkg::pix565_t frame_mem [FRAME_H][FRAME_W];  // current input frame
    vp_pkg::pix565_t exp_q [$];                     // model output
    vp_pkg::pix565_t got_q [$];                     // captured output

    int seed;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    ahb_vp dut0 (
        .clk_vpm   (clk_vpm),
        .arst_n_i  (arst_n_i),
        .vi_clk_i  (vi_clk_i),
        .vi_vs_i   (vi_vs_i),
        .vi_de_i   (vi_de_i),
        .vi_data_i (vi_data_i),
        .vp_vs_o   (vp_vs_o),
        .vp_de_o   (vp_de_o),
        .vp_data_o (vp_data_o)
    );

    always #10 clk_vpm = ~clk_vpm;    // 20 ns
    always #15 vi_clk_i = ~vi_clk_i;  // 30 ns is slower than clk_vpm

    // outputs change on the rising edge and are taken on the falling one
    always @(negedge clk_vpm) begin
        if (arst_n_i && vp_de_o) got_q.push_back(vp_data_o);
    end

    task automatic check_pix(input string name, input vp_pkg::pix565_t got,
                             input vp_pkg::pix565_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input vp_pkg::coord_t got,
                               input vp_pkg::coord_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("%-30s ok", name);
        end else begin
            tests_failed++;
            $display("%-30s failed with %0d errors", name, errors - err_start);
        end
    endtask

    // nearest neighbour picks source index floor(k * step) in Q4.14
    function automatic int src_col(input int k);
        return `VP_CUT_X0 + ((k * `VP_X_STEP) >> `VP_SCALE_FRAC);
    endfunction

    function automatic int src_row(input int j);
        return `VP_CUT_Y0 + ((j * `VP_Y_STEP) >> `VP_SCALE_FRAC);
    endfunction

    task automatic vi_step();
        @(posedge vi_clk_i);
        #2;  // inputs change just after the vi edge
    endtask

    task automatic fill_frame(input bit ones);
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                frame_mem[y][x] = vp_pkg::pix565_t'($random(seed));
            end
        end
        if (ones) begin  // full scale values on two sampled positions
            frame_mem[src_row(2)][src_col(3)] = 16'hFFFF;
            frame_mem[src_row(`VP_OUT_H - 1)][src_col(`VP_OUT_W - 1)] = 16'hFFFF;
        end
    endtask

    // expected stream is the scaled window plus a black tail per line
    task automatic build_expect();
        exp_q.delete();
        for (int j = 0; j < `VP_OUT_H; j++) begin
            for (int k = 0; k < `VP_OUT_W; k++) begin
                exp_q.push_back(frame_mem[src_row(j)][src_col(k)]);  // 565 to 888 and back is lossless
            end
            for (int k = 0; k < PAD_W; k++) begin
                exp_q.push_back(16'h0000);
            end
        end
    endtask

    task automatic drive_frame(input int gap_max);
        int gap;
        vi_step();
        vi_vs_i = 1'b1;          // frame opens
        repeat (3) vi_step();
        check_level("vp_vs_o", vp_vs_o, 1'b1);  // vs passes straight through
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                vi_step();
                vi_de_i   = 1'b1;
                vi_data_i = frame_mem[y][x];
            end
            gap = 1 + ({$random(seed)} % gap_max);  // horizontal blanking
            for (int g = 0; g < gap; g++) begin
                vi_step();
                vi_de_i   = 1'b0;
                vi_data_i = '0;
            end
        end
        vi_step();
        vi_vs_i = 1'b0;
        vi_step();
        check_level("vp_vs_o", vp_vs_o, 1'b0);
    endtask

    task automatic wait_pixels(input int n);
        int cyc;
        cyc = 0;
        while (got_q.size() < n && cyc < WAIT_MAX) begin
            @(posedge clk_vpm);
            cyc++;
        end
        if (got_q.size() < n) begin
            errors++;
            $display("timeout at %0t ns, only %0d of %0d output pixels arrived",
                     $time, got_q.size(), n);
        end
    endtask

    task automatic run_frame(input string tag, input int gap_max, input bit ones);
        int err_start;
        int n;
        err_start = errors;
        fill_frame(ones);
        build_expect();
        got_q.delete();
        drive_frame(gap_max);
        end_test({tag, " vs pass-through"}, err_start);
        err_start = errors;
        wait_pixels(FRAME_PIX);
        repeat (BLANK) vi_step();  // late extra pixels would show here
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            if ((i % `VP_DISP_W) < `VP_OUT_W) begin
                check_pix($sformatf("vp_data_o[%0d]", i), got_q[i], exp_q[i]);
            end
        end
        end_test({tag, " scaled pixels"}, err_start);
        err_start = errors;
        for (int i = 0; i < n; i++) begin
            if ((i % `VP_DISP_W) >= `VP_OUT_W) begin
                check_pix($sformatf("vp_data_o[%0d]", i), got_q[i], 16'h0000);  // black
            end
        end
        end_test({tag, " black padding"}, err_start);
        err_start = errors;
        check_count("vp_de_o pixel count", vp_pkg::coord_t'(got_q.size()),
                    vp_pkg::coord_t'(FRAME_PIX));
        end_test({tag, " pixel count"}, err_start);
    endtask

    task automatic check_all_ones(input int j, input int k);
        int idx;
        idx = j * `VP_DISP_W + k;
        if (idx < got_q.size()) begin
            check_pix($sformatf("vp_data_o[%0d]", idx), got_q[idx], 16'hFFFF);
        end else begin
            errors++;
            $display("output pixel %0d for line %0d column %0d never came out", idx, j, k);
        end
    endtask

    initial begin
        int err_start;
        seed         = 32'h7280_7452;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clk_vpm      = 1'b0;
        vi_clk_i     = 1'b0;
        arst_n_i     = 1'b0;
        vi_vs_i      = 1'b0;
        vi_de_i      = 1'b0;
        vi_data_i    = '0;
        repeat (4) @(posedge clk_vpm);
        #2;
        arst_n_i = 1'b1;

        // nothing may come out before a frame is sent
        err_start = errors;
        repeat (40) vi_step();
        check_count("vp_de_o after reset", vp_pkg::coord_t'(got_q.size()), '0);
        end_test("idle after reset", err_start);

        run_frame("frame 1", 4, 1'b0);
        run_frame("frame 2", 12, 1'b0);   // longer line gaps
        run_frame("frame 3", 2, 1'b1);

        err_start = errors;
        check_all_ones(2, 3);
        check_all_ones(`VP_OUT_H - 1, `VP_OUT_W - 1);
        end_test("all ones pixel", err_start);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== ahb_vp.f ====
+incdir+src
src/vp_pkg.sv
src/image_cut.sv
src/async_fifo.sv
src/stream_scaler.sv
src/fill_blank.sv
src/ahb_vp.sv
verif/tb_ahb_vp.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the ahb_vp testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f ahb_vp.f \
    --top-module tb_ahb_vp \
    -o tb_ahb_vp_sim

./obj_dir/tb_ahb_vp_sim | tee sim.log

# the log decides the result
if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
